//--- Makefile
TOP := tb_opcode_decoder
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -qx "all tests passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- logic/decoder_pkg.sv
// Opcode decoder package with word widths, opcode constants and the shared pipe and issue types.
package decoder_pkg;

// ==========================================================================
// Widths and opcode constants
// ==========================================================================
localparam int word_w = 16;                          // Instruction word width.

localparam logic [word_w-1:0] op_nop       = 16'h4E71;
localparam logic [word_w-1:0] op_illegal   = 16'h4AFC;  // Official ILLEGAL pattern.
localparam logic [word_w-1:0] op_rte       = 16'h4E73;
localparam logic [word_w-1:0] op_stop      = 16'h4E72;  // Immediate SR value follows.
localparam logic [word_w-1:0] op_ori_to_sr = 16'h007C;  // Immediate word follows.

// TRAP #n carries the vector number in the low nibble.
localparam logic [word_w-1:0] trap_mask  = 16'hFFF0;
localparam logic [word_w-1:0] trap_match = 16'h4E40;

// MOVE to SR, any source EA.
localparam logic [word_w-1:0] move_to_sr_mask  = 16'hFFC0;
localparam logic [word_w-1:0] move_to_sr_match = 16'h46C0;

localparam logic [7:0] bra_long_disp = 8'hFF;         // 32 bit displacement follows.
localparam logic [7:0] bra_word_disp = 8'h00;         // 16 bit displacement follows.

// ==========================================================================
// Decode results
// ==========================================================================
typedef enum logic [4:0] {
    OP_NOP,
    OP_ILLEGAL,
    OP_TRAP,
    OP_RTE,
    OP_STOP,
    OP_MOVE_TO_SR,
    OP_ORI,
    OP_ANDI,
    OP_SUBI,
    OP_ADDI,
    OP_EORI,
    OP_CMPI,
    OP_ORI_TO_SR,
    OP_BRANCH,
    OP_MOVEQ,
    OP_UNIMPLEMENTED,                                 // Line A and line F.
    OP_OTHER
} op_class_e;

// Words used by an operation are the encoding plus one.
typedef enum logic [1:0] {
    LVL_D = 2'd0,                                     // One word.
    LVL_C = 2'd1,                                     // Two words.
    LVL_B = 2'd2                                      // Three words.
} instr_lvl_e;

typedef enum logic [2:0] {
    T_NONE    = 3'd0,
    T_1010    = 3'd1,
    T_1111    = 3'd2,
    T_ILLEGAL = 3'd3,
    T_TRAP    = 3'd4,
    T_RTE     = 3'd5,                                 // RTE in supervisor mode.
    T_PRIV    = 3'd6                                  // Privilege violation.
} trap_code_e;

// ==========================================================================
// Instruction word views
// ==========================================================================
typedef struct packed {
    logic [3:0] line;
    logic [3:0] sub_op;
    logic [1:0] size;                                 // 10 selects long.
    logic [5:0] ea;
} imm_view_t;

typedef struct packed {
    logic [3:0] line;
    logic [3:0] cond;
    logic [7:0] disp;
} branch_view_t;

typedef union packed {
    imm_view_t    imm_view;
    branch_view_t branch_view;
} biw_word_u;

// Head of the prefetch pipe as seen by the decode stage.
typedef struct packed {
    biw_word_u  word_d;
    biw_word_u  word_c;
    biw_word_u  word_b;
    logic       fault_d;
    logic       fault_c;
    logic       fault_b;
    logic [1:0] count;                                // Valid words, 0 to 3.
} pipe_window_t;

typedef struct packed {
    op_class_e  op;
    instr_lvl_e lvl;
} decode_t;

typedef struct packed {
    op_class_e         op;
    trap_code_e        trap;
    logic [word_w-1:0] biw_0;
    logic [word_w-1:0] biw_1;
    logic [word_w-1:0] biw_2;
    logic              ow_valid;
    logic              fc;
    logic              fb;
} issue_out_t;

endpackage

//--- logic/instr_pipe.sv
// Instruction prefetch pipe, three words deep, with fault bits, read strobe and flush dismissal.
`timescale 1ns/1ps

module instr_pipe import decoder_pkg::*; (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              opcode_rdy,
    input  logic              opcode_valid,
    input  logic [word_w-1:0] opcode_data,
    input  logic              ipipe_flush,
    input  logic [1:0]        take,         // Words consumed at this edge.
    output logic              opcode_rd,
    output pipe_window_t      window
);

    biw_word_u  word_q [3];                 // Index 0 is stage D, 2 is stage B.
    biw_word_u  word_n [3];
    logic [2:0] fault_q;                    // One bit per stage, same order.
    logic [2:0] fault_n;
    logic [1:0] count_q;
    logic [1:0] count_n;
    logic [1:0] count_rem;                  // Fill level after the take.
    logic       dismissed_q;                // Outstanding read was overlapped by a flush.
    logic       rdy_eff;

    assign rdy_eff   = opcode_rdy && !dismissed_q;  // Ignore the dismissed word.
    assign count_rem = count_q - take;

    // ======================================================================
    // Shift and append
    // ======================================================================
    always_comb begin : pipe_next
        word_n  = word_q;
        fault_n = fault_q >> take;          // Faults shift toward D.
        count_n = count_rem;
        case (take)
            2'd1: begin
                word_n[0] = word_q[1];
                word_n[1] = word_q[2];
            end
            2'd2: word_n[0] = word_q[2];
            default: ;                      // Nothing moves, or all words leave.
        endcase
        // New word lands in the first free stage.
        if (rdy_eff && count_rem != 2'd3) begin
            word_n[count_rem]  = opcode_data;
            fault_n[count_rem] = !opcode_valid;  // Bus fault on this word.
            count_n            = count_rem + 2'd1;
        end
    end

    always_ff @(posedge CLK) begin : pipe_ctrl
        if (!rst_n) begin
            count_q <= 2'd0;
            fault_q <= 3'b000;
        end else if (ipipe_flush) begin
            count_q <= 2'd0;                // Flush wins over take and append.
            fault_q <= 3'b000;
        end else begin
            count_q <= count_n;
            fault_q <= fault_n;
        end
    end

    always_ff @(posedge CLK) begin : pipe_words
        word_q <= word_n;                   // Stale stages are masked by the count.
    end

    // ======================================================================
    // Read strobe
    // ======================================================================
    always_ff @(posedge CLK) begin : read_strobe
        if (!rst_n) begin
            opcode_rd <= 1'b0;
        end else if (opcode_rdy) begin
            opcode_rd <= 1'b0;              // Falls after each ready pulse.
        end else if (count_q != 2'd3) begin
            opcode_rd <= 1'b1;              // Room left, fetch again.
        end
    end

    always_ff @(posedge CLK) begin : read_dismiss
        if (!rst_n) begin
            dismissed_q <= 1'b0;
        end else if (ipipe_flush && opcode_rd && !opcode_rdy) begin
            dismissed_q <= 1'b1;            // Read still in flight.
        end else if (opcode_rdy) begin
            dismissed_q <= 1'b0;            // Its ready pulse has passed.
        end
    end

    assign window.word_d  = word_q[0];
    assign window.word_c  = word_q[1];
    assign window.word_b  = word_q[2];
    assign window.fault_d = fault_q[0];
    assign window.fault_c = fault_q[1];
    assign window.fault_b = fault_q[2];
    assign window.count   = count_q;

endmodule

//--- logic/issue_ctrl.sv
// Issue control, answers operation and extension requests and registers the issued words and flags.
`timescale 1ns/1ps

module issue_ctrl import decoder_pkg::*; (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              ow_req,
    input  logic              ew_req,
    input  logic              ipipe_flush,
    input  pipe_window_t      window,
    input  decode_t           dec,
    input  trap_code_e        trap,
    output logic [1:0]        take,
    output logic              opd_ack,
    output logic              ew_ack,
    output logic [word_w-1:0] ext_word,
    output issue_out_t        iss
);

    instr_lvl_e        lvl_eff;             // Level after the privilege override.
    logic [1:0]        lvl_words;
    logic              ow_issue;
    logic              ew_issue;
    op_class_e         op_q;
    trap_code_e        trap_q;
    logic [word_w-1:0] biw_q [3];
    logic              ow_valid_q;
    logic              fc_q;
    logic              fb_q;

    // A privileged op only carries its first word.
    assign lvl_eff   = (trap == T_PRIV) ? LVL_D : dec.lvl;
    assign lvl_words = 2'(lvl_eff) + 2'd1;

    // D and C need two words to fix the level, B needs all three.
    assign ow_issue = ow_req && !ipipe_flush &&
                      ((lvl_eff == LVL_B) ? (window.count == 2'd3) : (window.count >= 2'd2));
    assign ew_issue = ew_req && !ipipe_flush && (window.count != 2'd0);

    assign take = ow_issue ? lvl_words : (ew_issue ? 2'd1 : 2'd0);

    // ======================================================================
    // Acknowledges and issued state
    // ======================================================================
    always_ff @(posedge CLK) begin : ack_regs
        if (!rst_n) begin
            opd_ack <= 1'b0;
            ew_ack  <= 1'b0;
        end else begin
            opd_ack <= ow_issue;            // One cycle pulse.
            ew_ack  <= ew_issue;
        end
    end

    always_ff @(posedge CLK) begin : status_regs
        if (!rst_n) begin
            op_q       <= OP_NOP;
            trap_q     <= T_NONE;
            ow_valid_q <= 1'b0;
            fc_q       <= 1'b0;
            fb_q       <= 1'b0;
        end else if (ipipe_flush) begin
            trap_q     <= T_NONE;
            ow_valid_q <= 1'b0;
            fc_q       <= 1'b0;
            fb_q       <= 1'b0;
        end else if (ow_issue) begin
            op_q       <= dec.op;
            trap_q     <= trap;
            // Only the words in use count as faulted.
            ow_valid_q <= !(window.fault_d ||
                            (lvl_eff >= LVL_C && window.fault_c) ||
                            (lvl_eff == LVL_B && window.fault_b));
            fc_q       <= (lvl_eff >= LVL_C) && window.fault_c;
            fb_q       <= (lvl_eff == LVL_B) && window.fault_b;
        end
    end

    always_ff @(posedge CLK) begin : word_regs
        if (ow_issue) begin
            biw_q[0] <= window.word_d;      // All three copied, used or not.
            biw_q[1] <= window.word_c;
            biw_q[2] <= window.word_b;
        end
        if (ew_issue) begin
            ext_word <= window.word_d;
        end
    end

    assign iss = '{op: op_q, trap: trap_q, biw_0: biw_q[0], biw_1: biw_q[1],
                   biw_2: biw_q[2], ow_valid: ow_valid_q, fc: fc_q, fb: fb_q};

endmodule

//--- logic/op_decoder.sv
// Operation decoder, classifies the head pipe word into an operation class and a length level.
`timescale 1ns/1ps

module op_decoder import decoder_pkg::*; (
    input  pipe_window_t window,
    output decode_t      dec
);

    biw_word_u  w;                          // Head word, stage D.
    op_class_e  op_i;
    instr_lvl_e lvl_i;

    assign w = window.word_d;

    // ======================================================================
    // Operation class
    // ======================================================================
    always_comb begin : classify
        op_i = OP_OTHER;
        if (w == op_nop) begin
            op_i = OP_NOP;
        end else if (w == op_illegal) begin
            op_i = OP_ILLEGAL;
        end else if (w == op_rte) begin
            op_i = OP_RTE;
        end else if (w == op_stop) begin
            op_i = OP_STOP;
        end else if ((w & trap_mask) == trap_match) begin
            op_i = OP_TRAP;                 // Any of the sixteen vectors.
        end else if ((w & move_to_sr_mask) == move_to_sr_match) begin
            op_i = OP_MOVE_TO_SR;
        end else if (w == op_ori_to_sr) begin
            op_i = OP_ORI_TO_SR;            // Must precede the line 0 table.
        end else begin
            case (w.imm_view.line)
                4'h0: begin
                    // Immediate group, selected by bits 11 to 8.
                    case (w.imm_view.sub_op)
                        4'h0:    op_i = OP_ORI;
                        4'h2:    op_i = OP_ANDI;
                        4'h4:    op_i = OP_SUBI;
                        4'h6:    op_i = OP_ADDI;
                        4'hA:    op_i = OP_EORI;
                        4'hC:    op_i = OP_CMPI;
                        default: op_i = OP_OTHER;  // Bit ops and MOVEP.
                    endcase
                end
                4'h6:       op_i = OP_BRANCH;   // Bcc, BRA and BSR.
                4'h7:       op_i = OP_MOVEQ;
                4'hA, 4'hF: op_i = OP_UNIMPLEMENTED;
                default:    op_i = OP_OTHER;
            endcase
        end
    end

    // ======================================================================
    // Instruction level
    // ======================================================================
    always_comb begin : level
        case (op_i)
            OP_ORI, OP_ANDI, OP_SUBI, OP_ADDI, OP_EORI, OP_CMPI: begin
                // Long immediate takes two extra words.
                lvl_i = (w.imm_view.size == 2'b10) ? LVL_B : LVL_C;
            end
            OP_ORI_TO_SR, OP_STOP: lvl_i = LVL_C;
            OP_BRANCH: begin
                if (w.branch_view.disp == bra_long_disp) begin
                    lvl_i = LVL_B;
                end else if (w.branch_view.disp == bra_word_disp) begin
                    lvl_i = LVL_C;
                end else begin
                    lvl_i = LVL_D;          // 8 bit displacement in the opcode.
                end
            end
            default: lvl_i = LVL_D;
        endcase
    end

    assign dec.op  = op_i;
    assign dec.lvl = lvl_i;

endmodule

//--- logic/opcode_decoder_top.sv
// Opcode decoder top level, the prefetch pipe and decode stage of a 68030-compatible core.
`timescale 1ns/1ps

module opcode_decoder_top import decoder_pkg::*; (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              ow_req,       // Operation request, level.
    input  logic              ew_req,       // Extension request, level.
    input  logic              ipipe_flush,
    input  logic              sbit,
    input  logic              opcode_rdy,
    input  logic              opcode_valid,
    input  logic [word_w-1:0] opcode_data,
    output logic              opcode_rd,
    output logic              opd_ack,
    output logic              ew_ack,
    output logic [word_w-1:0] ext_word,
    output issue_out_t        iss
);

    pipe_window_t window;                   // Head of the pipe.
    decode_t      dec;
    trap_code_e   trap;
    logic [1:0]   take;

    instr_pipe instr_pipe_inst (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .opcode_rdy   (opcode_rdy),
        .opcode_valid (opcode_valid),
        .opcode_data  (opcode_data),
        .ipipe_flush  (ipipe_flush),
        .take         (take),
        .opcode_rd    (opcode_rd),
        .window       (window)
    );

    op_decoder op_decoder_inst (
        .window (window),
        .dec    (dec)
    );

    trap_check trap_check_inst (
        .window (window),
        .dec    (dec),
        .sbit   (sbit),
        .trap   (trap)
    );

    issue_ctrl issue_ctrl_inst (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .ow_req      (ow_req),
        .ew_req      (ew_req),
        .ipipe_flush (ipipe_flush),
        .window      (window),
        .dec         (dec),
        .trap        (trap),
        .take        (take),
        .opd_ack     (opd_ack),
        .ew_ack      (ew_ack),
        .ext_word    (ext_word),
        .iss         (iss)
    );

endmodule

//--- logic/trap_check.sv
// Trap check, derives the trap code from the head word, its class and the supervisor bit.
`timescale 1ns/1ps

module trap_check import decoder_pkg::*; (
    input  pipe_window_t window,
    input  decode_t      dec,
    input  logic         sbit,              // Supervisor mode.
    output trap_code_e   trap
);

    logic [3:0] line;

    assign line = window.word_d.imm_view.line;

    always_comb begin : trap_sel
        case (dec.op)
            OP_UNIMPLEMENTED: begin
                trap = (line == 4'hA) ? T_1010 : T_1111;  // Emulator lines.
            end
            OP_ILLEGAL: trap = T_ILLEGAL;
            OP_TRAP:    trap = T_TRAP;
            // RTE is taken as a trap in supervisor mode.
            OP_RTE:     trap = sbit ? T_RTE : T_PRIV;
            OP_STOP, OP_MOVE_TO_SR, OP_ORI_TO_SR: begin
                trap = sbit ? T_NONE : T_PRIV;    // Supervisor only.
            end
            default:    trap = T_NONE;
        endcase
    end

endmodule

//--- testbench/decoder_assertions.sv
// Bound protocol checks on the issue stage request and acknowledge handshake.
`timescale 1ns/1ps

module decoder_assertions (
    input logic CLK,
    input logic rst_n,
    input logic ow_req,
    input logic ew_req,
    input logic opd_ack,
    input logic ew_ack
);

    int fail_cnt = 0;                       // Failed assertions so far.

    // ======================================================================
    // Acknowledge rules
    // ======================================================================
    ack_exclusive: assert property (@(posedge CLK) disable iff (!rst_n) !(opd_ack && ew_ack))
        else begin
            $error("opd_ack and ew_ack are high in the same cycle");
            fail_cnt++;
        end

    // One cycle pulse with the request already dropped during it.
    opd_ack_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
                                    opd_ack |=> (!opd_ack && !$past(ow_req)))
        else begin
            $error("opd_ack longer than one cycle or ow_req held through it");
            fail_cnt++;
        end

    ew_ack_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
                                   ew_ack |=> (!ew_ack && !$past(ew_req)))
        else begin
            $error("ew_ack longer than one cycle or ew_req held through it");
            fail_cnt++;
        end

    acks_after_reset: assert property (@(posedge CLK) !rst_n |=> (!opd_ack && !ew_ack))
        else begin
            $error("acknowledge high in the cycle after reset");
            fail_cnt++;
        end

endmodule

bind issue_ctrl decoder_assertions decoder_assertions_inst (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .ow_req  (ow_req),
    .ew_req  (ew_req),
    .opd_ack (opd_ack),
    .ew_ack  (ew_ack)
);

//--- testbench/tb_opcode_decoder.sv
// Opcode decoder testbench that runs a stimulus table against the top level and a random-delay memory.
`timescale 1ns/1ps

module tb_opcode_decoder import decoder_pkg::*; ();

    typedef struct packed {
        logic              valid;               // Low marks a bus fault.
        logic [word_w-1:0] data;
    } bus_word_t;

    typedef struct packed {
        logic [0:2][word_w-1:0] words;          // Stream order with the head word first.
        logic [0:2]             valid;
        logic                   sbit;
        op_class_e              op;
        trap_code_e             trap;
        logic                   ow_valid;
        logic                   fc;
        logic                   fb;
        int                     len;            // Words used by the op.
        int                     ext_cnt;        // Extension words read after it.
    } test_entry_t;

    logic              CLK;
    logic              rst_n;
    logic              ow_req;
    logic              ew_req;
    logic              ipipe_flush;
    logic              sbit;
    logic              opcode_rdy;
    logic              opcode_valid;
    logic [word_w-1:0] opcode_data;
    logic              opcode_rd;
    logic              opd_ack;
    logic              ew_ack;
    logic [word_w-1:0] ext_word;
    issue_out_t        iss;

    test_entry_t table_q [$];
    string       name_q [$];
    bus_word_t   stream_q [$];                  // Words the memory hands out next.
    string       cur_name;
    int          checks = 0;
    int          errors = 0;

    opcode_decoder_top opcode_decoder_top_inst (.*);  // Port names match one to one.

    initial begin : clock_gen
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // ======================================================================
    // Memory model
    // ======================================================================
    initial begin : memory_model
        int        wait_cnt;
        logic      in_read;
        logic      stale;                       // Answer of this read gets dropped.
        bus_word_t w;
        void'($urandom(32'ha4fa9730));
        wait_cnt = 0;
        in_read  = 1'b0;
        stale    = 1'b0;
        forever begin
            @(posedge CLK);
            // Flush over an open read.
            if (ipipe_flush && opcode_rd && !opcode_rdy) stale = 1'b1;
            @(negedge CLK);
            if (opcode_rdy) begin
                // Read strobe falls at the edge that takes the ready pulse.
                check_flag("opcode_rd after ready", 1'b0, opcode_rd);
                opcode_rdy = 1'b0;              // Ready is a single cycle.
                in_read    = 1'b0;
                stale      = 1'b0;
            end else if (opcode_rd) begin
                if (!in_read) begin
                    in_read  = 1'b1;
                    wait_cnt = $urandom % 4;    // 0 to 3 cycles.
                end
                if (wait_cnt == 0) begin
                    if (stale) begin
                        w = bus_word_t'{valid: 1'b1, data: 16'hDEAD};  // Must never issue.
                    end else if (stream_q.size() != 0) begin
                        w = stream_q.pop_front();
                    end else begin
                        w = bus_word_t'{valid: 1'b1, data: op_nop};    // Filler.
                    end
                    opcode_data  = w.data;
                    opcode_valid = w.valid;
                    opcode_rdy   = 1'b1;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // ======================================================================
    // Checks and bus tasks
    // ======================================================================
    task automatic check_op(input string what, input op_class_e exp, input op_class_e got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0s %0s expected %0s actual %0s", cur_name, what, exp.name(), got.name());
        end
    endtask

    task automatic check_trap(input string what, input trap_code_e exp, input trap_code_e got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0s %0s expected %0s actual %0s", cur_name, what, exp.name(), got.name());
        end
    endtask

    task automatic check_word(input string what, input logic [word_w-1:0] exp,
                              input logic [word_w-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0s %0s expected %h actual %h", cur_name, what, exp, got);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0s %0s expected %b actual %b", cur_name, what, exp, got);
        end
    endtask

    // Stream word at a position with NOP filler after the entry's own words.
    function automatic logic [word_w-1:0] stream_word(input test_entry_t e, input int pos);
        case (pos)
            0:       return e.words[0];
            1:       return e.words[1];
            2:       return e.words[2];
            default: return op_nop;
        endcase
    endfunction

    // Starts and ends on a falling edge.
    task automatic flush_pipe(input test_entry_t e);
        ipipe_flush = 1'b1;
        sbit        = e.sbit;
        @(posedge CLK);
        stream_q.delete();                      // New stream after the flush edge.
        stream_q.push_back(bus_word_t'{valid: e.valid[0], data: e.words[0]});
        stream_q.push_back(bus_word_t'{valid: e.valid[1], data: e.words[1]});
        stream_q.push_back(bus_word_t'{valid: e.valid[2], data: e.words[2]});
        @(negedge CLK);
        ipipe_flush = 1'b0;
    endtask

    task automatic request_op(output issue_out_t got);
        @(negedge CLK);
        ow_req = 1'b1;
        @(negedge CLK);
        while (!opd_ack) @(negedge CLK);
        got    = iss;
        ow_req = 1'b0;                          // Dropped in the acknowledge cycle.
    endtask

    task automatic request_ext(output logic [word_w-1:0] got);
        @(negedge CLK);
        ew_req = 1'b1;
        @(negedge CLK);
        while (!ew_ack) @(negedge CLK);
        got    = ext_word;
        ew_req = 1'b0;
    endtask

    task automatic add_entry(input string name, input test_entry_t e);
        name_q.push_back(name);
        table_q.push_back(e);
    endtask

    task automatic fill_table();
        add_entry("addi_long", test_entry_t'{{16'h0680, 16'h1234, 16'h5678}, 3'b111, 1'b1,
                  OP_ADDI, T_NONE, 1'b1, 1'b0, 1'b0, 3, 0});
        add_entry("bra_word", test_entry_t'{{16'h6000, 16'h0010, 16'h7005}, 3'b111, 1'b1,
                  OP_BRANCH, T_NONE, 1'b1, 1'b0, 1'b0, 2, 0});
        add_entry("moveq", test_entry_t'{{16'h7001, 16'h7202, 16'h4E71}, 3'b111, 1'b1,
                  OP_MOVEQ, T_NONE, 1'b1, 1'b0, 1'b0, 1, 0});
        add_entry("line_a", test_entry_t'{{16'hA123, 16'h7003, 16'h4E71}, 3'b111, 1'b1,
                  OP_UNIMPLEMENTED, T_1010, 1'b1, 1'b0, 1'b0, 1, 0});
        add_entry("line_f", test_entry_t'{{16'hF200, 16'h7004, 16'h4E71}, 3'b111, 1'b1,
                  OP_UNIMPLEMENTED, T_1111, 1'b1, 1'b0, 1'b0, 1, 0});
        add_entry("illegal", test_entry_t'{{16'h4AFC, 16'h7006, 16'h4E71}, 3'b111, 1'b1,
                  OP_ILLEGAL, T_ILLEGAL, 1'b1, 1'b0, 1'b0, 1, 0});
        add_entry("trap_5", test_entry_t'{{16'h4E45, 16'h7008, 16'h4E71}, 3'b111, 1'b1,
                  OP_TRAP, T_TRAP, 1'b1, 1'b0, 1'b0, 1, 0});
        add_entry("rte_super", test_entry_t'{{16'h4E73, 16'h7009, 16'h4E71}, 3'b111, 1'b1,
                  OP_RTE, T_RTE, 1'b1, 1'b0, 1'b0, 1, 0});
        add_entry("rte_user", test_entry_t'{{16'h4E73, 16'h700A, 16'h4E71}, 3'b111, 1'b0,
                  OP_RTE, T_PRIV, 1'b1, 1'b0, 1'b0, 1, 0});
        // Privileged ops in user mode keep only their first word.
        add_entry("ori_sr_user", test_entry_t'{{16'h007C, 16'h2700, 16'h7001}, 3'b111, 1'b0,
                  OP_ORI_TO_SR, T_PRIV, 1'b1, 1'b0, 1'b0, 1, 0});
        add_entry("move_sr_user", test_entry_t'{{16'h46FC, 16'h2000, 16'h7002}, 3'b111, 1'b0,
                  OP_MOVE_TO_SR, T_PRIV, 1'b1, 1'b0, 1'b0, 1, 0});
        add_entry("ori_sr_super", test_entry_t'{{16'h007C, 16'h2700, 16'h7007}, 3'b111, 1'b1,
                  OP_ORI_TO_SR, T_NONE, 1'b1, 1'b0, 1'b0, 2, 0});
        add_entry("fault_c", test_entry_t'{{16'h0640, 16'h1234, 16'h7001}, 3'b101, 1'b1,
                  OP_ADDI, T_NONE, 1'b0, 1'b1, 1'b0, 2, 0});
        add_entry("fault_b", test_entry_t'{{16'h0680, 16'h1234, 16'h5678}, 3'b110, 1'b1,
                  OP_ADDI, T_NONE, 1'b0, 1'b0, 1'b1, 3, 0});
        add_entry("moveq_ext", test_entry_t'{{16'h7001, 16'h1111, 16'h2222}, 3'b111, 1'b1,
                  OP_MOVEQ, T_NONE, 1'b1, 1'b0, 1'b0, 1, 2});
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin : stimulus
        issue_out_t        got;
        logic [word_w-1:0] ext;
        test_entry_t       e;
        int                pos;
        int                assert_fails;
        rst_n        = 1'b0;
        ow_req       = 1'b0;
        ew_req       = 1'b0;
        ipipe_flush  = 1'b0;
        sbit         = 1'b1;
        opcode_rdy   = 1'b0;
        opcode_valid = 1'b1;
        opcode_data  = op_nop;
        fill_table();
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        for (int i = 0; i < table_q.size(); i++) begin
            e        = table_q[i];
            cur_name = name_q[i];
            @(negedge CLK);
            flush_pipe(e);
            @(negedge CLK);
            while (!opcode_rd) @(negedge CLK);
            flush_pipe(e);                      // Lands on an open read.
            request_op(got);
            check_op("op", e.op, got.op);
            check_trap("trap", e.trap, got.trap);
            check_flag("ow_valid", e.ow_valid, got.ow_valid);
            check_flag("fc", e.fc, got.fc);
            check_flag("fb", e.fb, got.fb);
            check_word("biw_0", e.words[0], got.biw_0);
            if (e.len > 1) check_word("biw_1", e.words[1], got.biw_1);
            if (e.len > 2) check_word("biw_2", e.words[2], got.biw_2);
            pos = e.len;
            for (int k = 0; k < e.ext_cnt; k++) begin
                request_ext(ext);
                check_word("ext_word", stream_word(e, pos), ext);
                pos++;
            end
            request_op(got);                    // Next op shows the length used.
            check_word("next biw_0", stream_word(e, pos), got.biw_0);
        end
        assert_fails = opcode_decoder_top_inst.issue_ctrl_inst.decoder_assertions_inst.fail_cnt;
        $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        @(posedge CLK);
        repeat (table_q.size() * 60) @(posedge CLK);
        $display("Timeout, an acknowledge did not arrive in the time allowed for the table.");
        $display("tests failed");
        $finish;
    end

endmodule

//--- vlog.f
logic/decoder_pkg.sv
logic/instr_pipe.sv
logic/op_decoder.sv
logic/trap_check.sv
logic/issue_ctrl.sv
logic/opcode_decoder_top.sv
testbench/decoder_assertions.sv
testbench/tb_opcode_decoder.sv
